// File: source/isu_defs.svh
// sizing macros for the bank instruction scheduling unit
// included by the package and by any module that sizes storage

`ifndef ISU_DEFS_SVH
`define ISU_DEFS_SVH

// issue queue
`define ISU_IQ_DEPTH    16
`define ISU_IQ_PTR_W    4

// crossbar channels
`define ISU_NUM_CH      3
`define ISU_CH_W        2
`define ISU_ROB_W       3
`define ISU_CREDIT_W    3

// linefill slot is set times 8 plus way
`define ISU_SET_W       3
`define ISU_WAY_W       3
`define ISU_SETWAY_W    6

// request fields
`define ISU_OPCODE_W    2
`define ISU_SWO_W       7
`define ISU_WBUF_W      8
`define ISU_STATE_W     2

// line data
`define ISU_LINE_W      256
`define ISU_HALF_W      128

`endif

// File: source/isu_pkg.sv
// shared types of the scheduling unit
// imported by the RTL modules and the testbench

`default_nettype none

`include "isu_defs.svh"

package isu_pkg;

  //--------------------------------------------------------------------
  // request side
  //--------------------------------------------------------------------
  // only channels 0..2 are legal
  typedef logic [`ISU_CH_W-1:0]       ch_id_t;
  typedef logic [`ISU_OPCODE_W-1:0]   opcode_t;
  typedef logic [`ISU_SWO_W-1:0]      set_way_off_t;
  typedef logic [`ISU_WBUF_W-1:0]     wbuf_id_t;
  // state of one cacheline half
  typedef logic [`ISU_STATE_W-1:0]    line_state_t;

  //--------------------------------------------------------------------
  // linefill side
  //--------------------------------------------------------------------
  // slot index that doubles as the biu read id
  typedef logic [`ISU_SETWAY_W-1:0]   setway_t;
  typedef logic [`ISU_LINE_W-1:0]     line_t;
  typedef logic [`ISU_HALF_W-1:0]     half_line_t;

  //--------------------------------------------------------------------
  // sc and crossbar side
  //--------------------------------------------------------------------
  // need_linefill on top of the request opcode
  typedef logic [`ISU_OPCODE_W:0]     sc_opcode_t;
  typedef logic [`ISU_ROB_W-1:0]      rob_num_t;
  typedef logic [`ISU_CREDIT_W-1:0]   credit_t;

endpackage

`default_nettype wire

// File: source/isu_iq.sv
// in-order issue queue for htu requests
// also hands out the per-channel crossbar rob number at acceptance

`timescale 1ns/100ps
`default_nettype none

`include "isu_defs.svh"

module isu_iq import isu_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  // push side
  input  logic         req_valid_i,
  output logic         req_allow_in_o,
  input  logic         req_need_linefill_i,
  input  setway_t      req_setway_i,
  input  ch_id_t       req_ch_id_i,
  input  opcode_t      req_opcode_i,
  input  set_way_off_t req_set_way_offset_i,
  input  wbuf_id_t     req_wbuffer_id_i,
  input  line_state_t  req_state0_i,
  input  line_state_t  req_state1_i,
  // pop side
  input  logic         pop_i,
  output logic         head_valid_o,
  output logic         head_need_linefill_o,
  output setway_t      head_setway_o,
  output ch_id_t       head_ch_id_o,
  output opcode_t      head_opcode_o,
  output set_way_off_t head_set_way_offset_o,
  output wbuf_id_t     head_wbuffer_id_o,
  output rob_num_t     head_rob_num_o,
  output line_state_t  head_state0_o,
  output line_state_t  head_state1_o
);

  logic [`ISU_IQ_PTR_W-1:0] wr_ptr_q;
  logic [`ISU_IQ_PTR_W-1:0] rd_ptr_q;
  logic [`ISU_IQ_PTR_W:0]   count_q;
  logic [`ISU_IQ_PTR_W:0]   count_next;
  logic                     allow_in_q;
  logic                     kickoff;
  rob_num_t                 req_rob;

  rob_num_t     rob_cnt_q [`ISU_NUM_CH];

  // entry storage
  logic         need_fill_mem [`ISU_IQ_DEPTH];
  setway_t      setway_mem    [`ISU_IQ_DEPTH];
  ch_id_t       ch_id_mem     [`ISU_IQ_DEPTH];
  opcode_t      opcode_mem    [`ISU_IQ_DEPTH];
  set_way_off_t swo_mem       [`ISU_IQ_DEPTH];
  wbuf_id_t     wbuf_mem      [`ISU_IQ_DEPTH];
  rob_num_t     rob_mem       [`ISU_IQ_DEPTH];
  line_state_t  state0_mem    [`ISU_IQ_DEPTH];
  line_state_t  state1_mem    [`ISU_IQ_DEPTH];

  assign req_allow_in_o = allow_in_q;
  assign kickoff        = req_valid_i & allow_in_q;

  //--------------------------------------------------------------------
  // occupancy
  //--------------------------------------------------------------------
  always_comb begin
    case ({kickoff, pop_i})
      2'b10:   count_next = count_q + 1'b1;
      2'b01:   count_next = count_q - 1'b1;
      default: count_next = count_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      allow_in_q <= 1'b1;
    end else begin
      if (kickoff) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)   rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q    <= count_next;
      // allowIn drops on the edge that fills the last slot
      allow_in_q <= (count_next < `ISU_IQ_DEPTH);
    end
  end

  //--------------------------------------------------------------------
  // rob number per channel
  //--------------------------------------------------------------------
  always_comb begin
    req_rob = '0;
    for (int c = 0; c < `ISU_NUM_CH; c++) begin
      if (req_ch_id_i == ch_id_t'(c)) req_rob = rob_cnt_q[c];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int c = 0; c < `ISU_NUM_CH; c++) rob_cnt_q[c] <= '0;
    end else if (kickoff) begin
      for (int c = 0; c < `ISU_NUM_CH; c++) begin
        if (req_ch_id_i == ch_id_t'(c)) rob_cnt_q[c] <= rob_cnt_q[c] + 1'b1;
      end
    end
  end

  // payload write
  always_ff @(posedge clk_i) begin
    if (kickoff) begin
      need_fill_mem[wr_ptr_q] <= req_need_linefill_i;
      setway_mem[wr_ptr_q]    <= req_setway_i;
      ch_id_mem[wr_ptr_q]     <= req_ch_id_i;
      opcode_mem[wr_ptr_q]    <= req_opcode_i;
      swo_mem[wr_ptr_q]       <= req_set_way_offset_i;
      wbuf_mem[wr_ptr_q]      <= req_wbuffer_id_i;
      rob_mem[wr_ptr_q]       <= req_rob;
      state0_mem[wr_ptr_q]    <= req_state0_i;
      state1_mem[wr_ptr_q]    <= req_state1_i;
    end
  end

  // head of queue
  assign head_valid_o          = (count_q != '0);
  assign head_need_linefill_o  = need_fill_mem[rd_ptr_q];
  assign head_setway_o         = setway_mem[rd_ptr_q];
  assign head_ch_id_o          = ch_id_mem[rd_ptr_q];
  assign head_opcode_o         = opcode_mem[rd_ptr_q];
  assign head_set_way_offset_o = swo_mem[rd_ptr_q];
  assign head_wbuffer_id_o     = wbuf_mem[rd_ptr_q];
  assign head_rob_num_o        = rob_mem[rd_ptr_q];
  assign head_state0_o         = state0_mem[rd_ptr_q];
  assign head_state1_o         = state1_mem[rd_ptr_q];

  // scheduler must only pop a live head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> head_valid_o);

  // htu only sends channels 0..2
  a_ch_id_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    kickoff |-> (req_ch_id_i < `ISU_NUM_CH));

endmodule

`default_nettype wire

// File: source/isu_linefill_unit.sv
// tracks linefills in flight per set/way slot and keeps the returned lines
// the biu writes a whole line per beat and the scheduler reads one slot

`timescale 1ns/100ps
`default_nettype none

`include "isu_defs.svh"

module isu_linefill_unit import isu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  // fill request from an accepted htu miss
  input  logic    fill_req_i,
  input  setway_t fill_setway_i,
  // biu read data beat
  input  logic    rvalid_i,
  input  setway_t rid_i,
  input  line_t   rdata_i,
  // scheduler lookup
  input  setway_t query_setway_i,
  output logic    pending_o,
  output line_t   line_o
);

  localparam int NUM_SLOTS = 2 ** `ISU_SETWAY_W;

  logic [NUM_SLOTS-1:0] inflight_q;
  logic [NUM_SLOTS-1:0] set_mask;
  logic [NUM_SLOTS-1:0] clr_mask;

  line_t lines_q [NUM_SLOTS];

  //--------------------------------------------------------------------
  // in-flight bitmap
  //--------------------------------------------------------------------
  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (fill_req_i) set_mask[fill_setway_i] = 1'b1;
    if (rvalid_i)   clr_mask[rid_i]         = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= (inflight_q & ~clr_mask) | set_mask;
    end
  end

  //--------------------------------------------------------------------
  // line storage
  //--------------------------------------------------------------------
  // one beat carries the full line since rready is always high
  always_ff @(posedge clk_i) begin
    if (rvalid_i) lines_q[rid_i] <= rdata_i;
  end

  // both results are seen the cycle after the beat edge
  assign pending_o = inflight_q[query_setway_i];
  assign line_o    = lines_q[query_setway_i];

  // the htu never requests a slot that is still being filled
  a_fill_not_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    fill_req_i |-> !inflight_q[fill_setway_i]);

  // the biu only returns lines that were requested
  a_beat_is_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> inflight_q[rid_i]);

endmodule

`default_nettype wire

// File: source/isu_sched.sv
// issue decision for the queue head and assembly of the sc transaction
// purely combinational, the queue and linefill unit hold the state

`timescale 1ns/100ps
`default_nettype none

module isu_sched import isu_pkg::*; (
  // queue head
  input  logic         head_valid_i,
  input  logic         head_need_linefill_i,
  input  setway_t      head_setway_i,
  input  ch_id_t       head_ch_id_i,
  input  opcode_t      head_opcode_i,
  input  set_way_off_t head_set_way_offset_i,
  input  wbuf_id_t     head_wbuffer_id_i,
  input  rob_num_t     head_rob_num_i,
  input  line_state_t  head_state0_i,
  input  line_state_t  head_state1_i,
  // linefill lookup
  input  logic         pending_i,
  input  line_t        line_i,
  output setway_t      query_setway_o,
  // crossbar credit levels
  input  credit_t      credit0_i,
  input  credit_t      credit1_i,
  input  credit_t      credit2_i,
  // sc transaction
  input  logic         sc_ready_i,
  output logic         pop_o,
  output logic         sc_valid_o,
  output ch_id_t       sc_channel_id_o,
  output sc_opcode_t   sc_opcode_o,
  output set_way_off_t sc_set_way_offset_o,
  output wbuf_id_t     sc_wbuffer_id_o,
  output rob_num_t     sc_rob_num_o,
  output line_state_t  sc_dirty0_o,
  output line_state_t  sc_dirty1_o,
  output half_line_t   sc_data0_o,
  output half_line_t   sc_data1_o
);

  credit_t head_credit;
  logic    credit_ok;
  logic    fill_ok;

  //--------------------------------------------------------------------
  // issue decision
  //--------------------------------------------------------------------
  // credit of the head's channel
  always_comb begin
    case (head_ch_id_i)
      2'd0:    head_credit = credit0_i;
      2'd1:    head_credit = credit1_i;
      2'd2:    head_credit = credit2_i;
      default: head_credit = '0;
    endcase
  end

  assign credit_ok = (head_credit != '0);

  // hits go right away, misses wait for the line
  assign query_setway_o = head_setway_i;
  assign fill_ok        = !head_need_linefill_i || !pending_i;

  assign sc_valid_o = head_valid_i & credit_ok & fill_ok;
  assign pop_o      = sc_valid_o & sc_ready_i;

  //--------------------------------------------------------------------
  // sc fields
  //--------------------------------------------------------------------
  assign sc_channel_id_o     = head_ch_id_i;
  assign sc_opcode_o         = {head_need_linefill_i, head_opcode_i};
  assign sc_set_way_offset_o = head_set_way_offset_i;
  assign sc_wbuffer_id_o     = head_wbuffer_id_i;
  assign sc_rob_num_o        = head_rob_num_i;
  assign sc_dirty0_o         = head_state0_i;
  assign sc_dirty1_o         = head_state1_i;

  // line halves only for linefill requests
  assign sc_data0_o = head_need_linefill_i ? line_i[`ISU_HALF_W-1:0] : '0;
  assign sc_data1_o = head_need_linefill_i ? line_i[`ISU_LINE_W-1:`ISU_HALF_W] : '0;

endmodule

`default_nettype wire

// File: source/bank_isu_top.sv
// instruction scheduling unit of one cache bank
// htu requests queue in order and issue to the sc once credit and linefill allow

`timescale 1ns/100ps
`default_nettype none

`include "isu_defs.svh"

module bank_isu_top import isu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // htu to isu
  input  logic                  htu_isu_valid_i,
  output logic                  htu_isu_allowIn_o,
  input  logic                  htu_isu_need_linefill_i,
  input  logic [`ISU_SET_W-1:0] htu_isu_linefill_set_i,
  input  logic [`ISU_WAY_W-1:0] htu_isu_linefill_way_i,
  input  ch_id_t                htu_isu_ch_id_i,
  input  opcode_t               htu_isu_opcode_i,
  input  set_way_off_t          htu_isu_set_way_offset_i,
  input  wbuf_id_t              htu_isu_wbuffer_id_i,
  input  line_state_t           htu_isu_cacheline_offset0_state_i,
  input  line_state_t           htu_isu_cacheline_offset1_state_i,
  // biu to isu
  input  logic                  biu_isu_rvalid_i,
  output logic                  biu_isu_rready_o,
  input  line_t                 biu_isu_rdata_i,
  input  setway_t               biu_isu_rid_i,
  // isu to sc
  output logic                  isu_sc_valid_o,
  input  logic                  isu_sc_ready_i,
  output ch_id_t                isu_sc_channel_id_o,
  output sc_opcode_t            isu_sc_opcode_o,
  output set_way_off_t          isu_sc_set_way_offset_o,
  output wbuf_id_t              isu_sc_wbuffer_id_o,
  output rob_num_t              isu_sc_xbar_rob_num_o,
  output line_state_t           isu_sc_cacheline_dirty_offset0_o,
  output line_state_t           isu_sc_cacheline_dirty_offset1_o,
  output half_line_t            isu_sc_linefill_data_offset0_o,
  output half_line_t            isu_sc_linefill_data_offset1_o,
  // crossbar credit levels
  input  credit_t               xbar_isu_ch0_credit_i,
  input  credit_t               xbar_isu_ch1_credit_i,
  input  credit_t               xbar_isu_ch2_credit_i
);

  logic         kickoff;
  logic         fill_req;
  setway_t      req_setway;
  logic         pop;
  setway_t      query_setway;
  logic         pending;
  line_t        query_line;

  logic         head_valid;
  logic         head_need_linefill;
  setway_t      head_setway;
  ch_id_t       head_ch_id;
  opcode_t      head_opcode;
  set_way_off_t head_set_way_offset;
  wbuf_id_t     head_wbuffer_id;
  rob_num_t     head_rob_num;
  line_state_t  head_state0;
  line_state_t  head_state1;

  // every beat is taken
  assign biu_isu_rready_o = 1'b1;

  // ---------------------------------------------------------------------
  // linefill slot and request
  // ---------------------------------------------------------------------
  assign req_setway = {htu_isu_linefill_set_i, htu_isu_linefill_way_i};
  assign kickoff    = htu_isu_valid_i & htu_isu_allowIn_o;
  assign fill_req   = kickoff & htu_isu_need_linefill_i;

  isu_iq u_iq (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .req_valid_i           (htu_isu_valid_i),
    .req_allow_in_o        (htu_isu_allowIn_o),
    .req_need_linefill_i   (htu_isu_need_linefill_i),
    .req_setway_i          (req_setway),
    .req_ch_id_i           (htu_isu_ch_id_i),
    .req_opcode_i          (htu_isu_opcode_i),
    .req_set_way_offset_i  (htu_isu_set_way_offset_i),
    .req_wbuffer_id_i      (htu_isu_wbuffer_id_i),
    .req_state0_i          (htu_isu_cacheline_offset0_state_i),
    .req_state1_i          (htu_isu_cacheline_offset1_state_i),
    .pop_i                 (pop),
    .head_valid_o          (head_valid),
    .head_need_linefill_o  (head_need_linefill),
    .head_setway_o         (head_setway),
    .head_ch_id_o          (head_ch_id),
    .head_opcode_o         (head_opcode),
    .head_set_way_offset_o (head_set_way_offset),
    .head_wbuffer_id_o     (head_wbuffer_id),
    .head_rob_num_o        (head_rob_num),
    .head_state0_o         (head_state0),
    .head_state1_o         (head_state1)
  );

  isu_linefill_unit u_linefill (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fill_req_i     (fill_req),
    .fill_setway_i  (req_setway),
    .rvalid_i       (biu_isu_rvalid_i),
    .rid_i          (biu_isu_rid_i),
    .rdata_i        (biu_isu_rdata_i),
    .query_setway_i (query_setway),
    .pending_o      (pending),
    .line_o         (query_line)
  );

  // ---------------------------------------------------------------------
  // issue to sc
  // ---------------------------------------------------------------------
  isu_sched u_sched (
    .head_valid_i          (head_valid),
    .head_need_linefill_i  (head_need_linefill),
    .head_setway_i         (head_setway),
    .head_ch_id_i          (head_ch_id),
    .head_opcode_i         (head_opcode),
    .head_set_way_offset_i (head_set_way_offset),
    .head_wbuffer_id_i     (head_wbuffer_id),
    .head_rob_num_i        (head_rob_num),
    .head_state0_i         (head_state0),
    .head_state1_i         (head_state1),
    .pending_i             (pending),
    .line_i                (query_line),
    .query_setway_o        (query_setway),
    .credit0_i             (xbar_isu_ch0_credit_i),
    .credit1_i             (xbar_isu_ch1_credit_i),
    .credit2_i             (xbar_isu_ch2_credit_i),
    .sc_ready_i            (isu_sc_ready_i),
    .pop_o                 (pop),
    .sc_valid_o            (isu_sc_valid_o),
    .sc_channel_id_o       (isu_sc_channel_id_o),
    .sc_opcode_o           (isu_sc_opcode_o),
    .sc_set_way_offset_o   (isu_sc_set_way_offset_o),
    .sc_wbuffer_id_o       (isu_sc_wbuffer_id_o),
    .sc_rob_num_o          (isu_sc_xbar_rob_num_o),
    .sc_dirty0_o           (isu_sc_cacheline_dirty_offset0_o),
    .sc_dirty1_o           (isu_sc_cacheline_dirty_offset1_o),
    .sc_data0_o            (isu_sc_linefill_data_offset0_o),
    .sc_data1_o            (isu_sc_linefill_data_offset1_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_bank_isu.sv
// testbench for the bank scheduling unit
// random htu, biu, credit and ready traffic checked against a queue model

`timescale 1ns/100ps
`default_nettype none

`include "isu_defs.svh"

module tb_bank_isu import isu_pkg::*; ();

  localparam int NUM_REQ    = 400;
  localparam int MAX_CYCLES = NUM_REQ * 50;

  logic         clk_i;
  logic         rst_i;
  logic         htu_valid;
  logic         allow_in;
  logic         htu_need_fill;
  logic [2:0]   htu_set;
  logic [2:0]   htu_way;
  ch_id_t       htu_ch_id;
  opcode_t      htu_opcode;
  set_way_off_t htu_swo;
  wbuf_id_t     htu_wbuf;
  line_state_t  htu_st0;
  line_state_t  htu_st1;
  logic         biu_rvalid;
  logic         biu_rready;
  line_t        biu_rdata;
  setway_t      biu_rid;
  logic         sc_valid;
  logic         sc_ready;
  ch_id_t       sc_ch_id;
  sc_opcode_t   sc_opcode;
  set_way_off_t sc_swo;
  wbuf_id_t     sc_wbuf;
  rob_num_t     sc_rob;
  line_state_t  sc_dirty0;
  line_state_t  sc_dirty1;
  half_line_t   sc_data0;
  half_line_t   sc_data1;
  credit_t      ch0_credit;
  credit_t      ch1_credit;
  credit_t      ch2_credit;

  // expected sc transaction for each accepted request
  typedef struct packed {
    logic         fill;
    setway_t      slot;
    ch_id_t       ch;
    opcode_t      op;
    set_way_off_t swo;
    wbuf_id_t     wbuf;
    rob_num_t     rob;
    line_state_t  st0;
    line_state_t  st1;
  } exp_req_t;

  exp_req_t exp_q[$];
  int       acc_cnt [3];
  bit       pend [64];
  int       slot_use [64];
  line_t    sent_line [64];
  int       total_acc;

  bank_isu_top dut (
    .clk_i                             (clk_i),
    .rst_i                             (rst_i),
    .htu_isu_valid_i                   (htu_valid),
    .htu_isu_allowIn_o                 (allow_in),
    .htu_isu_need_linefill_i           (htu_need_fill),
    .htu_isu_linefill_set_i            (htu_set),
    .htu_isu_linefill_way_i            (htu_way),
    .htu_isu_ch_id_i                   (htu_ch_id),
    .htu_isu_opcode_i                  (htu_opcode),
    .htu_isu_set_way_offset_i          (htu_swo),
    .htu_isu_wbuffer_id_i              (htu_wbuf),
    .htu_isu_cacheline_offset0_state_i (htu_st0),
    .htu_isu_cacheline_offset1_state_i (htu_st1),
    .biu_isu_rvalid_i                  (biu_rvalid),
    .biu_isu_rready_o                  (biu_rready),
    .biu_isu_rdata_i                   (biu_rdata),
    .biu_isu_rid_i                     (biu_rid),
    .isu_sc_valid_o                    (sc_valid),
    .isu_sc_ready_i                    (sc_ready),
    .isu_sc_channel_id_o               (sc_ch_id),
    .isu_sc_opcode_o                   (sc_opcode),
    .isu_sc_set_way_offset_o           (sc_swo),
    .isu_sc_wbuffer_id_o               (sc_wbuf),
    .isu_sc_xbar_rob_num_o             (sc_rob),
    .isu_sc_cacheline_dirty_offset0_o  (sc_dirty0),
    .isu_sc_cacheline_dirty_offset1_o  (sc_dirty1),
    .isu_sc_linefill_data_offset0_o    (sc_data0),
    .isu_sc_linefill_data_offset1_o    (sc_data1),
    .xbar_isu_ch0_credit_i             (ch0_credit),
    .xbar_isu_ch1_credit_i             (ch1_credit),
    .xbar_isu_ch2_credit_i             (ch2_credit)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #(MAX_CYCLES * 10);
    $display("watchdog expired before all requests were issued to the sc");
    $display("Done: errors found");
    $fatal(1);
  end

  // --------------------------------------------------------------------
  // checking and model
  // --------------------------------------------------------------------
  task automatic check_eq(input logic [255:0] actual, input logic [255:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  // outputs have settled here and the events apply at the coming edge
  task automatic check_and_update;
    exp_req_t h;
    exp_req_t n;
    credit_t  cr;
    logic     exp_valid;
    line_t    l;
    h = '0;
    cr = '0;
    exp_valid = 1'b0;
    check_eq(allow_in, exp_q.size() < `ISU_IQ_DEPTH, "htu allowIn");
    if (exp_q.size() > 0) begin
      h = exp_q[0];
      cr = (h.ch == 2'd0) ? ch0_credit : (h.ch == 2'd1) ? ch1_credit : ch2_credit;
      exp_valid = (cr != '0) && !(h.fill && pend[h.slot]);
    end
    check_eq(sc_valid, exp_valid, "sc valid");
    if (exp_valid) begin
      l = h.fill ? sent_line[h.slot] : '0;
      check_eq(sc_ch_id, h.ch, "sc channel id");
      check_eq(sc_opcode, {h.fill, h.op}, "sc opcode");
      check_eq(sc_swo, h.swo, "sc set_way_offset");
      check_eq(sc_wbuf, h.wbuf, "sc wbuffer id");
      check_eq(sc_rob, h.rob, "sc rob number");
      check_eq(sc_dirty0, h.st0, "sc dirty offset0");
      check_eq(sc_dirty1, h.st1, "sc dirty offset1");
      check_eq(sc_data0, l[127:0], "sc linefill data offset0");
      check_eq(sc_data1, l[255:128], "sc linefill data offset1");
    end
    if (sc_valid && sc_ready) begin
      void'(exp_q.pop_front());
      if (h.fill) slot_use[h.slot]--;
    end
    if (biu_rvalid) pend[biu_rid] = 1'b0;
    if (htu_valid && allow_in) begin
      n.fill = htu_need_fill;
      n.slot = {htu_set, htu_way};
      n.ch   = htu_ch_id;
      n.op   = htu_opcode;
      n.swo  = htu_swo;
      n.wbuf = htu_wbuf;
      n.rob  = rob_num_t'(acc_cnt[htu_ch_id] % 8);
      n.st0  = htu_st0;
      n.st1  = htu_st1;
      exp_q.push_back(n);
      acc_cnt[htu_ch_id]++;
      if (htu_need_fill) begin
        pend[n.slot] = 1'b1;
        slot_use[n.slot]++;
      end
      total_acc++;
    end
  endtask

  task automatic wait_drive_time;
    @(posedge clk_i);
    #1;
  endtask

  task automatic settle_and_check;
    #8;
    check_and_update();
  endtask

  // --------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------
  // fills only to slots no queued request still refers to
  task automatic send_request(input int pct, input bit allow_fill);
    setway_t s;
    s = setway_t'($urandom);
    htu_valid     = ($urandom % 100) < pct;
    htu_ch_id     = ch_id_t'($urandom % 3);
    htu_opcode    = opcode_t'($urandom);
    htu_swo       = set_way_off_t'($urandom);
    htu_wbuf      = wbuf_id_t'($urandom);
    htu_st0       = line_state_t'($urandom);
    htu_st1       = line_state_t'($urandom);
    htu_need_fill = allow_fill && (($urandom % 100) < 40) && (slot_use[s] == 0);
    {htu_set, htu_way} = s;
  endtask

  task automatic send_beat(input int pct);
    setway_t cand[$];
    line_t   d;
    biu_rvalid = 1'b0;
    for (int i = 0; i < 64; i++) begin
      if (pend[i]) cand.push_back(setway_t'(i));
    end
    if (cand.size() > 0 && ($urandom % 100) < pct) begin
      for (int w = 0; w < 8; w++) d[w*32 +: 32] = $urandom;
      biu_rvalid = 1'b1;
      biu_rid    = cand[$urandom % cand.size()];
      biu_rdata  = d;
      sent_line[biu_rid] = d;
    end
  endtask

  task automatic set_credits(input int zero_pct);
    ch0_credit = (($urandom % 100) < zero_pct) ? '0 : credit_t'(1 + $urandom % 7);
    ch1_credit = (($urandom % 100) < zero_pct) ? '0 : credit_t'(1 + $urandom % 7);
    ch2_credit = (($urandom % 100) < zero_pct) ? '0 : credit_t'(1 + $urandom % 7);
  endtask

  initial begin
    void'($urandom(32'h43e2));
    rst_i = 1'b1;
    htu_valid = 1'b0;
    htu_need_fill = 1'b0;
    {htu_set, htu_way} = '0;
    htu_ch_id = '0;
    htu_opcode = '0;
    htu_swo = '0;
    htu_wbuf = '0;
    htu_st0 = '0;
    htu_st1 = '0;
    biu_rvalid = 1'b0;
    biu_rdata = '0;
    biu_rid = '0;
    sc_ready = 1'b0;
    ch0_credit = 3'd7;
    ch1_credit = 3'd7;
    ch2_credit = 3'd7;
    repeat (10) @(posedge clk_i);
    #1 rst_i = 1'b0;
    #8;
    check_eq(sc_valid, 1'b0, "sc valid after reset");
    check_eq(allow_in, 1'b1, "allowIn after reset");
    check_eq(biu_rready, 1'b1, "biu rready");

    // queue fills with the sc stalled
    repeat (`ISU_IQ_DEPTH + 4) begin
      wait_drive_time();
      send_request(100, 1'b0);
      sc_ready = 1'b0;
      settle_and_check();
    end
    check_eq(total_acc, `ISU_IQ_DEPTH, "accepts while sc stalled");
    check_eq(allow_in, 1'b0, "allowIn with full queue");
    wait_drive_time();
    htu_valid = 1'b0;
    sc_ready = 1'b1;
    settle_and_check();
    wait_drive_time();
    sc_ready = 1'b0;
    settle_and_check();
    check_eq(allow_in, 1'b1, "allowIn after one pop");

    // random traffic
    while (total_acc < NUM_REQ) begin
      wait_drive_time();
      send_request(60, 1'b1);
      send_beat(30);
      set_credits(20);
      sc_ready = ($urandom % 100) < 70;
      settle_and_check();
    end

    // drain
    while (exp_q.size() > 0) begin
      wait_drive_time();
      htu_valid = 1'b0;
      send_beat(50);
      set_credits(10);
      sc_ready = 1'b1;
      settle_and_check();
    end

    // the last pop must leave the DUT idle
    wait_drive_time();
    htu_valid = 1'b0;
    biu_rvalid = 1'b0;
    sc_ready = 1'b0;
    settle_and_check();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: bank_isu_top.f
+incdir+source
source/isu_pkg.sv
source/isu_iq.sv
source/isu_linefill_unit.sv
source/isu_sched.sv
source/bank_isu_top.sv
testbench/tb_bank_isu.sv

// File: Makefile
# Verilator flow for the bank instruction scheduling unit

TB = tb_bank_isu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB) \
		-f bank_isu_top.f -o $(TB)

# the run passes only when the testbench printed its pass line
run: build
	@out="$$(./obj_dir/$(TB))"; echo "$$out"; \
		echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing -Wall --top-module bank_isu_top -f bank_isu_top.f

clean:
	rm -rf obj_dir
